//--- build.f
hdl/rv_pkg.sv
hdl/rv_regfile.sv
hdl/rv_decode.sv
hdl/rv_execute.sv
hdl/rv_result.sv
hdl/rv_core_top.sv
verification/rv_commit_checker.sv
verification/tb_rv_core.sv

//--- hdl/rv_core_top.sv
`timescale 1ns/10ps

module rv_core_top (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::word_t     inst_i,
  input  logic              inst_valid_i,
  output logic              inst_ready_o,
  output rv_pkg::word_t     pc_o,
  output logic              commit_valid_o,
  output rv_pkg::word_t     commit_pc_o,
  output rv_pkg::reg_addr_t commit_rd_o,
  output rv_pkg::word_t     commit_data_o,
  output logic              halted_o,
  output logic              illegal_o
);
  import rv_pkg::*;

  reg_addr_t rs1_addr, rs2_addr;
  word_t     rs1_data, rs2_data;
  logic      rf_wen;
  reg_addr_t rf_waddr;
  word_t     rf_wdata;

  // Decode to execute.
  logic      dec_valid, exe_ready;
  word_t     dec_op1, dec_op2, dec_base, dec_imm, dec_sdata;
  alu_op_t   dec_alu_op;
  logic [2:0] dec_funct3;
  reg_addr_t dec_rd;
  logic      dec_wen, dec_jump, dec_branch, dec_load, dec_store, dec_system, dec_illegal;

  // Execute to result.
  logic      exe_valid, res_ready;
  word_t     exe_result, exe_target, exe_sdata;
  logic      exe_take;
  reg_addr_t exe_rd;
  logic [2:0] exe_funct3;
  logic      exe_wen, exe_load, exe_store, exe_system, exe_illegal;

  rv_decode rv_decode_i (
    .clk          (clk),
    .rst          (rst),
    .inst_i       (inst_i),
    .inst_valid_i (inst_valid_i),
    .inst_ready_o (inst_ready_o),
    .pc_i         (pc_o),
    .commit_i     (commit_valid_o),
    .rs1_addr_o   (rs1_addr),
    .rs2_addr_o   (rs2_addr),
    .rs1_data_i   (rs1_data),
    .rs2_data_i   (rs2_data),
    .valid_o      (dec_valid),
    .ready_i      (exe_ready),
    .op1_o        (dec_op1),
    .op2_o        (dec_op2),
    .jump_base_o  (dec_base),
    .imm_o        (dec_imm),
    .store_data_o (dec_sdata),
    .alu_op_o     (dec_alu_op),
    .funct3_o     (dec_funct3),
    .rd_o         (dec_rd),
    .reg_wen_o    (dec_wen),
    .jump_o       (dec_jump),
    .branch_o     (dec_branch),
    .load_o       (dec_load),
    .store_o      (dec_store),
    .system_o     (dec_system),
    .illegal_o    (dec_illegal)
  );

  rv_execute rv_execute_i (
    .clk          (clk),
    .rst          (rst),
    .valid_i      (dec_valid),
    .ready_o      (exe_ready),
    .op1_i        (dec_op1),
    .op2_i        (dec_op2),
    .jump_base_i  (dec_base),
    .imm_i        (dec_imm),
    .store_data_i (dec_sdata),
    .alu_op_i     (dec_alu_op),
    .funct3_i     (dec_funct3),
    .rd_i         (dec_rd),
    .reg_wen_i    (dec_wen),
    .jump_i       (dec_jump),
    .branch_i     (dec_branch),
    .load_i       (dec_load),
    .store_i      (dec_store),
    .system_i     (dec_system),
    .illegal_i    (dec_illegal),
    .valid_o      (exe_valid),
    .ready_i      (res_ready),
    .result_o     (exe_result),
    .target_o     (exe_target),
    .store_data_o (exe_sdata),
    .take_jump_o  (exe_take),
    .rd_o         (exe_rd),
    .funct3_o     (exe_funct3),
    .reg_wen_o    (exe_wen),
    .load_o       (exe_load),
    .store_o      (exe_store),
    .system_o     (exe_system),
    .illegal_o    (exe_illegal)
  );

  rv_result rv_result_i (
    .clk            (clk),
    .rst            (rst),
    .valid_i        (exe_valid),
    .ready_o        (res_ready),
    .result_i       (exe_result),
    .target_i       (exe_target),
    .store_data_i   (exe_sdata),
    .take_jump_i    (exe_take),
    .rd_i           (exe_rd),
    .funct3_i       (exe_funct3),
    .reg_wen_i      (exe_wen),
    .load_i         (exe_load),
    .store_i        (exe_store),
    .system_i       (exe_system),
    .illegal_i      (exe_illegal),
    .rf_wen_o       (rf_wen),
    .rf_waddr_o     (rf_waddr),
    .rf_wdata_o     (rf_wdata),
    .pc_o           (pc_o),
    .commit_valid_o (commit_valid_o),
    .commit_pc_o    (commit_pc_o),
    .commit_rd_o    (commit_rd_o),
    .commit_data_o  (commit_data_o),
    .halted_o       (halted_o),
    .illegal_o      (illegal_o)
  );

  rv_regfile rv_regfile_i (
    .clk        (clk),
    .rst        (rst),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wen_i      (rf_wen),
    .waddr_i    (rf_waddr),
    .wdata_i    (rf_wdata)
  );

endmodule

//--- hdl/rv_decode.sv
`timescale 1ns/10ps

module rv_decode (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::word_t     inst_i,
  input  logic              inst_valid_i,
  output logic              inst_ready_o,
  input  rv_pkg::word_t     pc_i,
  input  logic              commit_i,
  output rv_pkg::reg_addr_t rs1_addr_o,
  output rv_pkg::reg_addr_t rs2_addr_o,
  input  rv_pkg::word_t     rs1_data_i,
  input  rv_pkg::word_t     rs2_data_i,
  output logic              valid_o,
  input  logic              ready_i,
  output rv_pkg::word_t     op1_o,
  output rv_pkg::word_t     op2_o,
  output rv_pkg::word_t     jump_base_o,
  output rv_pkg::word_t     imm_o,
  output rv_pkg::word_t     store_data_o,
  output rv_pkg::alu_op_t   alu_op_o,
  output logic [2:0]        funct3_o,
  output rv_pkg::reg_addr_t rd_o,
  output logic              reg_wen_o,
  output logic              jump_o,
  output logic              branch_o,
  output logic              load_o,
  output logic              store_o,
  output logic              system_o,
  output logic              illegal_o
);
  import rv_pkg::*;

  bus_state_e state_q;
  logic       busy_q;
  logic       accept;
  logic       stop;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

  word_t   op1, op2, base, imm;
  alu_op_t alu_op;
  logic    wen, jump, branch, load, store, system, illegal;

  assign opcode     = inst_i[6:0];
  assign funct3     = inst_i[14:12];
  assign funct7     = inst_i[31:25];
  assign rs1_addr_o = inst_i[19:15];
  assign rs2_addr_o = inst_i[24:20];

  assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_s = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u = {inst_i[31:12], 12'b0};
  assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  // A halting instruction keeps the core busy until the next reset.
  assign stop         = system_o || illegal_o;
  assign inst_ready_o = (state_q == IDLE) && (!busy_q || (commit_i && !stop));
  assign accept       = inst_valid_i && inst_ready_o;
  assign valid_o      = (state_q == WAIT_READY);

  always_comb begin
    op1     = '0;
    op2     = '0;
    base    = '0;
    imm     = '0;
    alu_op  = ALU_ADD;
    wen     = 1'b0;
    jump    = 1'b0;
    branch  = 1'b0;
    load    = 1'b0;
    store   = 1'b0;
    system  = 1'b0;
    illegal = 1'b0;
    case (opcode)
      OP_LUI: begin
        op2 = imm_u;
        wen = 1'b1;
      end
      OP_AUIPC: begin
        op1 = pc_i;
        op2 = imm_u;
        wen = 1'b1;
      end
      OP_JAL, OP_JALR: begin
        op1  = pc_i;  // The ALU yields the link address.
        op2  = 32'd4;
        base = (opcode == OP_JAL) ? pc_i : rs1_data_i;
        imm  = (opcode == OP_JAL) ? imm_j : imm_i;
        wen  = 1'b1;
        jump = 1'b1;
      end
      OP_BRANCH: begin
        op1    = rs1_data_i;
        op2    = rs2_data_i;
        base   = pc_i;
        imm    = imm_b;
        alu_op = ALU_SUB;
        branch = 1'b1;
      end
      OP_LOAD: begin
        op1  = rs1_data_i;
        op2  = imm_i;
        wen  = 1'b1;
        load = 1'b1;
      end
      OP_STORE: begin
        op1   = rs1_data_i;
        op2   = imm_s;
        store = 1'b1;
      end
      OP_IMM: begin
        op1    = rs1_data_i;
        op2    = imm_i;
        alu_op = {(funct3 == 3'b101) ? funct7[5] : 1'b0, funct3};  // Only SRAI uses bit 30.
        wen    = 1'b1;
      end
      OP_REG: begin
        op1    = rs1_data_i;
        op2    = rs2_data_i;
        alu_op = {funct7[5], funct3};
        wen    = 1'b1;
      end
      OP_SYSTEM: system = 1'b1;
      default:   illegal = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= IDLE;
      busy_q  <= 1'b0;
    end else begin
      if (accept) begin
        busy_q <= 1'b1;
      end else if (commit_i && !stop) begin
        busy_q <= 1'b0;
      end
      if (state_q == IDLE && accept) begin
        state_q <= WAIT_READY;
      end else if (state_q == WAIT_READY && ready_i) begin
        state_q <= IDLE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      reg_wen_o <= 1'b0;
      jump_o    <= 1'b0;
      branch_o  <= 1'b0;
      load_o    <= 1'b0;
      store_o   <= 1'b0;
      system_o  <= 1'b0;
      illegal_o <= 1'b0;
    end else if (accept) begin
      reg_wen_o <= wen;
      jump_o    <= jump;
      branch_o  <= branch;
      load_o    <= load;
      store_o   <= store;
      system_o  <= system;
      illegal_o <= illegal;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      op1_o        <= op1;
      op2_o        <= op2;
      jump_base_o  <= base;
      imm_o        <= imm;
      store_data_o <= rs2_data_i;
      alu_op_o     <= alu_op;
      funct3_o     <= funct3;
      rd_o         <= wen ? inst_i[11:7] : 5'd0;
    end
  end

endmodule

//--- hdl/rv_execute.sv
`timescale 1ns/10ps

module rv_execute (
  input  logic              clk,
  input  logic              rst,
  input  logic              valid_i,
  output logic              ready_o,
  input  rv_pkg::word_t     op1_i,
  input  rv_pkg::word_t     op2_i,
  input  rv_pkg::word_t     jump_base_i,
  input  rv_pkg::word_t     imm_i,
  input  rv_pkg::word_t     store_data_i,
  input  rv_pkg::alu_op_t   alu_op_i,
  input  logic [2:0]        funct3_i,
  input  rv_pkg::reg_addr_t rd_i,
  input  logic              reg_wen_i,
  input  logic              jump_i,
  input  logic              branch_i,
  input  logic              load_i,
  input  logic              store_i,
  input  logic              system_i,
  input  logic              illegal_i,
  output logic              valid_o,
  input  logic              ready_i,
  output rv_pkg::word_t     result_o,
  output rv_pkg::word_t     target_o,
  output rv_pkg::word_t     store_data_o,
  output logic              take_jump_o,
  output rv_pkg::reg_addr_t rd_o,
  output logic [2:0]        funct3_o,
  output logic              reg_wen_o,
  output logic              load_o,
  output logic              store_o,
  output logic              system_o,
  output logic              illegal_o
);
  import rv_pkg::*;

  bus_state_e state_q;
  logic       accept;
  word_t      alu;
  word_t      sum;
  logic       cond;

  assign ready_o = (state_q == IDLE);
  assign valid_o = (state_q == WAIT_READY);
  assign accept  = valid_i && ready_o;

  always_comb begin
    case (alu_op_i)
      ALU_SUB:  alu = op1_i - op2_i;
      ALU_SLL:  alu = op1_i << op2_i[4:0];
      ALU_SLT:  alu = {31'b0, $signed(op1_i) < $signed(op2_i)};
      ALU_SLTU: alu = {31'b0, op1_i < op2_i};
      ALU_XOR:  alu = op1_i ^ op2_i;
      ALU_SRL:  alu = op1_i >> op2_i[4:0];
      ALU_SRA:  alu = $signed(op1_i) >>> op2_i[4:0];
      ALU_OR:   alu = op1_i | op2_i;
      ALU_AND:  alu = op1_i & op2_i;
      default:  alu = op1_i + op2_i;  // ALU_ADD, also the load and store address.
    endcase
  end

  always_comb begin
    case (funct3_i)
      3'b000:  cond = (op1_i == op2_i);
      3'b001:  cond = (op1_i != op2_i);
      3'b100:  cond = $signed(op1_i) < $signed(op2_i);
      3'b101:  cond = $signed(op1_i) >= $signed(op2_i);
      3'b110:  cond = op1_i < op2_i;
      3'b111:  cond = op1_i >= op2_i;
      default: cond = 1'b0;
    endcase
  end

  // Clearing bit 0 is what JALR needs and leaves the other aligned targets alone.
  assign sum = jump_base_i + imm_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= IDLE;
      take_jump_o <= 1'b0;
      reg_wen_o   <= 1'b0;
      load_o      <= 1'b0;
      store_o     <= 1'b0;
      system_o    <= 1'b0;
      illegal_o   <= 1'b0;
    end else if (state_q == IDLE) begin
      if (accept) begin
        state_q     <= WAIT_READY;
        take_jump_o <= jump_i || (branch_i && cond);
        reg_wen_o   <= reg_wen_i;
        load_o      <= load_i;
        store_o     <= store_i;
        system_o    <= system_i;
        illegal_o   <= illegal_i;
      end
    end else if (ready_i) begin
      state_q <= IDLE;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      result_o     <= alu;
      target_o     <= {sum[31:1], 1'b0};
      store_data_o <= store_data_i;
      rd_o         <= rd_i;
      funct3_o     <= funct3_i;
    end
  end

endmodule

//--- hdl/rv_pkg.sv
package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [3:0]  alu_op_t;  // {funct7[5], funct3}.

  // ALU operations.
  localparam alu_op_t ALU_ADD  = 4'b0000;
  localparam alu_op_t ALU_SUB  = 4'b1000;
  localparam alu_op_t ALU_SLL  = 4'b0001;
  localparam alu_op_t ALU_SLT  = 4'b0010;
  localparam alu_op_t ALU_SLTU = 4'b0011;
  localparam alu_op_t ALU_XOR  = 4'b0100;
  localparam alu_op_t ALU_SRL  = 4'b0101;
  localparam alu_op_t ALU_SRA  = 4'b1101;
  localparam alu_op_t ALU_OR   = 4'b0110;
  localparam alu_op_t ALU_AND  = 4'b0111;

  // Major opcodes.
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // Access sizes as coded in funct3 of loads and stores.
  localparam logic [2:0] MEM_B  = 3'b000;
  localparam logic [2:0] MEM_H  = 3'b001;
  localparam logic [2:0] MEM_W  = 3'b010;
  localparam logic [2:0] MEM_BU = 3'b100;
  localparam logic [2:0] MEM_HU = 3'b101;

  localparam int DMEM_WORDS = 256;
  localparam int DMEM_AW    = $clog2(DMEM_WORDS);

  // Stage handshake controller states.
  typedef enum logic {
    IDLE,
    WAIT_READY
  } bus_state_e;

endpackage

//--- hdl/rv_regfile.sv
`timescale 1ns/10ps

module rv_regfile (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::reg_addr_t rs1_addr_i,
  input  rv_pkg::reg_addr_t rs2_addr_i,
  output rv_pkg::word_t     rs1_data_o,
  output rv_pkg::word_t     rs2_data_o,
  input  logic              wen_i,
  input  rv_pkg::reg_addr_t waddr_i,
  input  rv_pkg::word_t     wdata_i
);
  import rv_pkg::*;

  // x0 has no storage.
  word_t regs [1:31];

  assign rs1_data_o = (rs1_addr_i == 5'd0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == 5'd0) ? '0 : regs[rs2_addr_i];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen_i && waddr_i != 5'd0) begin
      regs[waddr_i] <= wdata_i;
    end
  end

endmodule

//--- hdl/rv_result.sv
`timescale 1ns/10ps

module rv_result (
  input  logic              clk,
  input  logic              rst,
  input  logic              valid_i,
  output logic              ready_o,
  input  rv_pkg::word_t     result_i,
  input  rv_pkg::word_t     target_i,
  input  rv_pkg::word_t     store_data_i,
  input  logic              take_jump_i,
  input  rv_pkg::reg_addr_t rd_i,
  input  logic [2:0]        funct3_i,
  input  logic              reg_wen_i,
  input  logic              load_i,
  input  logic              store_i,
  input  logic              system_i,
  input  logic              illegal_i,
  output logic              rf_wen_o,
  output rv_pkg::reg_addr_t rf_waddr_o,
  output rv_pkg::word_t     rf_wdata_o,
  output rv_pkg::word_t     pc_o,
  output logic              commit_valid_o,
  output rv_pkg::word_t     commit_pc_o,
  output rv_pkg::reg_addr_t commit_rd_o,
  output rv_pkg::word_t     commit_data_o,
  output logic              halted_o,
  output logic              illegal_o
);
  import rv_pkg::*;

  word_t              dmem [DMEM_WORDS];
  logic [DMEM_AW-1:0] widx;
  logic               fire;
  word_t              rdata, shifted, load_data;
  word_t              wdata;
  logic [3:0]         lane_en;

  assign ready_o = !halted_o;
  assign fire    = valid_i && ready_o;
  assign widx    = result_i[DMEM_AW+1:2];  // Wraps at the memory depth.

  assign rdata   = dmem[widx];
  assign shifted = rdata >> {result_i[1:0], 3'b000};

  always_comb begin
    case (funct3_i)
      MEM_B:   load_data = {{24{shifted[7]}}, shifted[7:0]};
      MEM_BU:  load_data = {24'b0, shifted[7:0]};
      MEM_H:   load_data = {{16{shifted[15]}}, shifted[15:0]};
      MEM_HU:  load_data = {16'b0, shifted[15:0]};
      default: load_data = rdata;
    endcase
  end

  // Narrow stores repeat their data across the word and pick lanes by address.
  always_comb begin
    case (funct3_i)
      MEM_B: begin
        lane_en = 4'b0001 << result_i[1:0];
        wdata   = {4{store_data_i[7:0]}};
      end
      MEM_H: begin
        lane_en = 4'b0011 << {result_i[1], 1'b0};
        wdata   = {2{store_data_i[15:0]}};
      end
      default: begin
        lane_en = 4'b1111;
        wdata   = store_data_i;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (fire && store_i) begin
      for (int i = 0; i < 4; i++) begin
        if (lane_en[i]) dmem[widx][8*i +: 8] <= wdata[8*i +: 8];
      end
    end
  end

  assign rf_wen_o   = fire && reg_wen_i;
  assign rf_waddr_o = rd_i;
  assign rf_wdata_o = load_i ? load_data : result_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_o           <= '0;
      commit_valid_o <= 1'b0;
      halted_o       <= 1'b0;
      illegal_o      <= 1'b0;
    end else begin
      commit_valid_o <= fire;
      if (fire) begin
        pc_o <= take_jump_i ? target_i : pc_o + 32'd4;
        if (system_i || illegal_i) halted_o <= 1'b1;
        if (illegal_i) illegal_o <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire) begin
      commit_pc_o   <= pc_o;  // Still the pc of the instruction being retired.
      commit_rd_o   <= rd_i;
      commit_data_o <= reg_wen_i ? rf_wdata_o : '0;
    end
  end

endmodule

//--- verification/rv_commit_checker.sv
`timescale 1ns/10ps

module rv_commit_checker (
  input  logic              clk,
  input  logic              rst,
  input  logic              inst_valid_i,
  input  logic              inst_ready_i,
  input  rv_pkg::word_t     pc_i,
  input  logic              commit_valid_i,
  input  rv_pkg::word_t     commit_pc_i,
  input  rv_pkg::reg_addr_t commit_rd_i,
  input  rv_pkg::word_t     commit_data_i,
  input  logic              halted_i,
  input  logic              illegal_i,
  input  int                exp_total_i,
  input  logic [127:0]      exp_name_i,
  input  rv_pkg::word_t     exp_pc_i,
  input  rv_pkg::reg_addr_t exp_rd_i,
  input  rv_pkg::word_t     exp_data_i,
  input  logic [1:0]        exp_halt_i,
  output int                index_o,
  output int                value_errors_o,
  output int                flow_errors_o
);
  import rv_pkg::*;

  int   index;
  int   value_errors = 0;
  int   flow_errors = 0;
  logic in_flight;
  logic accept;

  assign index_o        = index;
  assign value_errors_o = value_errors;
  assign flow_errors_o  = flow_errors;
  assign accept         = inst_valid_i && inst_ready_i;

  task automatic check_value(input string what, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("Fail %0s: %0s expected %h, actual %h.", exp_name_i, what, exp, act);
      value_errors++;
    end
  endtask

  task automatic flow_error(input string msg);
    $display("Error at %0t ns: %0s.", $time, msg);
    flow_errors++;
  endtask

  always @(posedge clk) begin
    if (rst) begin
      index     <= 0;
      in_flight <= 1'b0;
    end else begin
      if (commit_valid_i) begin
        if (!in_flight) flow_error("commit without an accepted instruction");
        if (index >= exp_total_i) begin
          flow_error("more commits than the expected trace holds");
        end else begin
          check_value("pc", exp_pc_i, commit_pc_i);
          check_value("rd", exp_rd_i, commit_rd_i);
          check_value("data", exp_data_i, commit_data_i);
          if (halted_i && exp_halt_i == 2'd0) begin
            flow_error("the core halted before the end of the expected trace");
          end else begin
            check_value("halted", exp_halt_i != 2'd0, halted_i);
            check_value("illegal", exp_halt_i == 2'd2, illegal_i);
          end
        end
        index <= index + 1;
      end
      // The fetch address must be the pc of the next expected commit.
      if (accept && !commit_valid_i && index < exp_total_i) begin
        check_value("fetch pc", exp_pc_i, pc_i);
      end
      // Ready may rise in the commit cycle so that the next fetch overlaps it.
      if (in_flight && !commit_valid_i && inst_ready_i) begin
        flow_error("inst_ready_o was high while an instruction was in flight");
      end
      if (halted_i && inst_ready_i) flow_error("inst_ready_o was high after the halt");
      in_flight <= (in_flight && !commit_valid_i) || accept;
    end
  end

endmodule

//--- verification/rv_testdata.txt
# Columns: test name, segment, pc (hex), instruction (hex), rd (dec), rd data (hex), halt.
# Halt is 0 while running, 1 for an ECALL halt and 2 for an illegal-opcode halt.
# Each line is one expected commit; the instruction is the program word at that pc.
# Segment 0 is the main program, segment 1 runs after a reset.
arith        0 00000000 123450b7  1 12345000 0  # lui   x1, 0x12345
arith        0 00000004 00001117  2 00001004 0  # auipc x2, 0x1
arith        0 00000008 ff800193  3 fffffff8 0  # addi  x3, x0, -8
arith        0 0000000c 4011d213  4 fffffffc 0  # srai  x4, x3, 1
arith        0 00000010 0011a2b3  5 00000001 0  # slt   x5, x3, x1
arith        0 00000014 40208333  6 12343ffc 0  # sub   x6, x1, x2
arith        0 00000018 0f024393  7 ffffff0c 0  # xori  x7, x4, 0xf0
x0_zero      0 0000001c 00500013  0 00000005 0  # addi  x0, x0, 5
x0_zero      0 00000020 00100433  8 12345000 0  # add   x8, x0, x1
control      0 00000024 00808463  0 00000000 0  # beq   x1, x8, +8 (taken)
control      0 0000002c 00809463  0 00000000 0  # bne   x1, x8, +8 (not taken)
control      0 00000030 00c004ef  9 00000034 0  # jal   x9, +12
control      0 0000003c 01048567 10 00000040 0  # jalr  x10, 16(x9)
memory       0 00000044 04102023  0 00000000 0  # sw    x1, 64(x0)
memory       0 00000048 043000a3  0 00000000 0  # sb    x3, 65(x0)
memory       0 0000004c 04701123  0 00000000 0  # sh    x7, 66(x0)
memory       0 00000050 04002583 11 ff0cf800 0  # lw    x11, 64(x0)
memory       0 00000054 04100603 12 fffffff8 0  # lb    x12, 65(x0)
memory       0 00000058 04104683 13 000000f8 0  # lbu   x13, 65(x0)
memory       0 0000005c 04201703 14 ffffff0c 0  # lh    x14, 66(x0)
memory       0 00000060 04205783 15 0000ff0c 0  # lhu   x15, 66(x0)
halt_ecall   0 00000064 00000073  0 00000000 1  # ecall
halt_illegal 1 00000000 00700093  1 00000007 0  # addi  x1, x0, 7
halt_illegal 1 00000004 00140133  2 00000007 0  # add   x2, x8, x1 (x8 cleared by reset)
halt_illegal 1 00000008 0000000b  0 00000000 2  # unknown opcode

//--- verification/tb_rv_core.sv
`timescale 1ns/10ps

module tb_rv_core;
  import rv_pkg::*;

  localparam int PROG_WORDS  = 64;
  localparam int MAX_ENTRIES = 64;
  localparam int CLK_PERIOD  = 40;

  logic      clk;
  logic      rst;
  word_t     inst;
  logic      inst_valid;
  logic      inst_ready;
  word_t     pc;
  logic      commit_valid;
  word_t     commit_pc;
  reg_addr_t commit_rd;
  word_t     commit_data;
  logic      halted;
  logic      illegal;

  word_t        prog [2][PROG_WORDS];  // One program per segment.
  logic [127:0] exp_name [MAX_ENTRIES];
  word_t        exp_pc [MAX_ENTRIES];
  reg_addr_t    exp_rd [MAX_ENTRIES];
  word_t        exp_data [MAX_ENTRIES];
  logic [1:0]   exp_halt [MAX_ENTRIES];
  int           seg_first [2];
  int           seg_count [2];
  int           n_entries;
  int           seg;
  int           commit_index;
  int           cur;
  int           value_errors;
  int           flow_errors;
  logic         loaded;

  assign cur = seg_first[seg] + commit_index;

  rv_core_top rv_core_top_i (
    .clk            (clk),
    .rst            (rst),
    .inst_i         (inst),
    .inst_valid_i   (inst_valid),
    .inst_ready_o   (inst_ready),
    .pc_o           (pc),
    .commit_valid_o (commit_valid),
    .commit_pc_o    (commit_pc),
    .commit_rd_o    (commit_rd),
    .commit_data_o  (commit_data),
    .halted_o       (halted),
    .illegal_o      (illegal)
  );

  rv_commit_checker commit_checker_i (
    .clk            (clk),
    .rst            (rst),
    .inst_valid_i   (inst_valid),
    .inst_ready_i   (inst_ready),
    .pc_i           (pc),
    .commit_valid_i (commit_valid),
    .commit_pc_i    (commit_pc),
    .commit_rd_i    (commit_rd),
    .commit_data_i  (commit_data),
    .halted_i       (halted),
    .illegal_i      (illegal),
    .exp_total_i    (seg_count[seg]),
    .exp_name_i     (exp_name[cur]),
    .exp_pc_i       (exp_pc[cur]),
    .exp_rd_i       (exp_rd[cur]),
    .exp_data_i     (exp_data[cur]),
    .exp_halt_i     (exp_halt[cur]),
    .index_o        (commit_index),
    .value_errors_o (value_errors),
    .flow_errors_o  (flow_errors)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  task automatic load_testdata(output bit ok);
    int           fd;
    int           n;
    string        line;
    logic [127:0] name;
    int           s, rd, halt;
    word_t        a, w, d;
    n_entries = 0;
    for (int i = 0; i < 2; i++) begin
      seg_first[i] = 0;
      seg_count[i] = 0;
      for (int j = 0; j < PROG_WORDS; j++) begin
        prog[i][j] = 32'hbad0_0000 | (i << 8) | j;  // Never fetched by a correct core.
      end
    end
    fd = $fopen("verification/rv_testdata.txt", "r");
    ok = (fd != 0);
    if (ok) begin
      while ($fgets(line, fd) > 0) begin
        n = $sscanf(line, "%s %d %h %h %d %h %d", name, s, a, w, rd, d, halt);
        if (n == 7 && s < 2 && n_entries < MAX_ENTRIES) begin
          prog[s][a[7:2]]     = w;
          exp_name[n_entries] = name;
          exp_pc[n_entries]   = a;
          exp_rd[n_entries]   = rd;
          exp_data[n_entries] = d;
          exp_halt[n_entries] = halt;
          if (seg_count[s] == 0) seg_first[s] = n_entries;
          seg_count[s]++;
          n_entries++;
        end
      end
      $fclose(fd);
    end
  endtask

  // Offers one instruction at a time and waits for its commit.
  task automatic run_segment(input int s);
    int gap;
    @(posedge clk);
    seg        <= s;
    rst        <= 1'b1;
    inst_valid <= 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    while (!halted) begin
      gap = $urandom % 4;
      repeat (gap) @(posedge clk);
      inst       <= prog[s][pc[7:2]];
      inst_valid <= 1'b1;
      do @(posedge clk); while (!inst_ready);
      inst_valid <= 1'b0;
      do @(posedge clk); while (!commit_valid);
    end
  endtask

  initial begin
    int seed;
    int seed_draw;
    bit ok;
    rst        = 1'b1;
    inst       = '0;
    inst_valid = 1'b0;
    seg        = 0;
    loaded     = 1'b0;
    seed       = 13;
    seed_draw  = $urandom(seed);
    load_testdata(ok);
    if (!ok) begin
      $display("Error: verification/rv_testdata.txt could not be opened.");
      $display("test failed");
      $finish;
    end else begin
      loaded = 1'b1;
      run_segment(0);
      run_segment(1);
      repeat (10) @(posedge clk);  // Room for any stray commit after the halt.
      $display("Errors: %0d wrong values, %0d protocol errors.", value_errors, flow_errors);
      if (value_errors + flow_errors == 0) begin
        $display("test passed");
      end else begin
        $display("test failed");
      end
      $finish;
    end
  end

  initial begin
    int limit;
    wait (loaded);
    limit = n_entries * 8 + 100;
    repeat (limit) @(posedge clk);
    $display("Error: timeout after %0d cycles, the trace did not finish.", limit);
    $display("test failed");
    $finish;
  end

endmodule
